//--- hw/uart_slave_params.svh
`ifndef UART_SLAVE_PARAMS_SVH
`define UART_SLAVE_PARAMS_SVH

// word carried on wD, rD and the two links
`define UART_SLAVE_DATA_WIDTH     32

// slave addressing inside the control frame
`define UART_SLAVE_ID_WIDTH       2
`define UART_SLAVE_ID             1
`define UART_SLAVE_START_PATTERN  3'b111

// 3 start bits, ID, read/write bit
`define UART_SLAVE_FRAME_BITS     6

// status nibble sent ahead of the read word
`define UART_SLAVE_STATUS_BITS    4

// acknowledge wait in clock cycles, and retransmission limit
`define UART_SLAVE_ACK_TIMEOUT    64
`define UART_SLAVE_RETRANSMITS    3

`endif

//--- hw/uart_slave_pkg.sv
`default_nettype none

`include "uart_slave_params.svh"

package uart_slave_pkg;

    typedef enum logic [3:0] {
        IDLE,
        FRAME,
        RX_WAIT,
        SEND_ACK,
        READ_OUT,
        READ_DONE,
        WRITE_IN,
        TX_START,
        ACK_WAIT
    } slave_state_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } rw_op_t;

    // upper nibble doubles as the status reported to the master
    typedef enum logic [7:0] {
        LINK_ACK = 8'hCC,
        LINK_NAK = 8'hAA
    } link_code_t;

    typedef logic [`UART_SLAVE_DATA_WIDTH-1:0] word_t;
    typedef logic [$clog2(`UART_SLAVE_ACK_TIMEOUT):0] ack_wait_t;
    typedef logic [$clog2(`UART_SLAVE_RETRANSMITS+1)-1:0] retry_cnt_t;

endpackage

`default_nettype wire

//--- hw/ack_timer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ack_timer_if;

    // requests from the state machine
    logic start;
    logic tick_clear;
    logic retry;

    // timer state back to the state machine
    logic timed_out;
    logic retries_left;

    modport fsm (output start, tick_clear, retry, input timed_out, retries_left);

    modport timer (input start, tick_clear, retry, output timed_out, retries_left);

endinterface

`default_nettype wire

//--- hw/control_frame_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_slave_params.svh"

module control_frame_decoder (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   control,
    input  logic                   sample_en,
    output logic                   frame_hit,
    output uart_slave_pkg::rw_op_t op
);
    import uart_slave_pkg::*;

    localparam int FRAME_BITS = `UART_SLAVE_FRAME_BITS;
    localparam int ID_WIDTH   = `UART_SLAVE_ID_WIDTH;
    localparam int CNT_W      = $clog2(FRAME_BITS);

    logic [FRAME_BITS-1:0] frame_q;
    logic [FRAME_BITS-1:0] frame_next;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  frame_start;
    logic                  frame_end;
    logic                  addr_match;

    // a nonzero count means a frame is being shifted in
    assign frame_start = (bit_cnt == '0) && sample_en && control;
    assign frame_end   = (bit_cnt == CNT_W'(FRAME_BITS - 1));
    assign frame_next  = {frame_q[FRAME_BITS-2:0], control};

    // start pattern on top, ID below it, rw bit last
    assign addr_match = (frame_next[FRAME_BITS-1 -: 3] == `UART_SLAVE_START_PATTERN) &&
                        (frame_next[ID_WIDTH:1] == ID_WIDTH'(`UART_SLAVE_ID));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt   <= '0;
            frame_hit <= 1'b0;
            op        <= OP_READ;
        end else begin
            frame_hit <= 1'b0;
            if (frame_start) begin
                bit_cnt <= CNT_W'(1);
            end else if (frame_end) begin
                bit_cnt   <= '0;
                frame_hit <= addr_match;
                if (addr_match) begin
                    op <= rw_op_t'(frame_next[0]);
                end
            end else if (bit_cnt != '0) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // msb first, so each new bit enters at the bottom
    always_ff @(posedge clk) begin
        if (frame_start || (bit_cnt != '0)) begin
            frame_q <= frame_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/write_shift_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_slave_params.svh"

module write_shift_buffer (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  wD,
    input  logic                  shift_en,
    input  logic                  load_tx,
    output logic                  word_full,
    output uart_slave_pkg::word_t tx_word
);
    import uart_slave_pkg::*;

    localparam int DATA_WIDTH = `UART_SLAVE_DATA_WIDTH;
    localparam int CNT_W      = $clog2(DATA_WIDTH + 1);

    word_t            shift_q;
    logic [CNT_W-1:0] bit_cnt;

    assign word_full = (bit_cnt == CNT_W'(DATA_WIDTH));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt <= '0;
        end else if (load_tx) begin
            bit_cnt <= '0;
        end else if (shift_en) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // tx_word is held for all retransmissions of this word
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_q <= {shift_q[DATA_WIDTH-2:0], wD};
        end
        if (load_tx) begin
            tx_word <= shift_q;
        end
    end

endmodule

`default_nettype wire

//--- hw/read_shift_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_slave_params.svh"

module read_shift_buffer (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  rx_load,
    input  uart_slave_pkg::word_t rx_word,
    input  logic                  status_load,
    input  logic                  status_ack,
    input  logic                  out_en,
    output logic                  rD,
    output logic                  out_last
);
    import uart_slave_pkg::*;

    localparam int STATUS_BITS = `UART_SLAVE_STATUS_BITS;
    localparam int TOTAL_BITS  = STATUS_BITS + `UART_SLAVE_DATA_WIDTH;
    localparam int CNT_W       = $clog2(TOTAL_BITS);
    localparam int CODE_MSB    = $bits(link_code_t) - 1;

    localparam logic [CODE_MSB:0] ACK_BITS = LINK_ACK;
    localparam logic [CODE_MSB:0] NAK_BITS = LINK_NAK;

    logic [STATUS_BITS-1:0] status_q;
    logic [TOTAL_BITS-1:0]  out_q;
    logic [CNT_W-1:0]       out_cnt;

    // status of the last write, 0000 until one completes
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            status_q <= '0;
        end else if (status_load) begin
            status_q <= status_ack ? ACK_BITS[CODE_MSB -: STATUS_BITS]
                                   : NAK_BITS[CODE_MSB -: STATUS_BITS];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            out_cnt <= '0;
        end else if (rx_load) begin
            out_cnt <= '0;
        end else if (out_en) begin
            out_cnt <= out_cnt + 1'b1;
        end
    end

    // status nibble goes out ahead of the word
    always_ff @(posedge clk) begin
        if (rx_load) begin
            out_q <= {status_q, rx_word};
        end else if (out_en) begin
            out_q <= {out_q[TOTAL_BITS-2:0], 1'b0};
        end
    end

    assign rD       = out_en && out_q[TOTAL_BITS-1];
    assign out_last = out_en && (out_cnt == CNT_W'(TOTAL_BITS - 1));

endmodule

`default_nettype wire

//--- hw/ack_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_slave_params.svh"

module ack_timer (
    input  logic        clk,
    input  logic        rstN,
    ack_timer_if.timer  tmr
);
    import uart_slave_pkg::*;

    ack_wait_t  wait_cnt;
    retry_cnt_t retry_cnt;
    logic       running;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wait_cnt  <= '0;
            retry_cnt <= '0;
            running   <= 1'b0;
        end else if (tmr.tick_clear) begin
            wait_cnt <= '0;
            running  <= 1'b0;
        end else if (tmr.start) begin
            wait_cnt  <= ack_wait_t'(`UART_SLAVE_ACK_TIMEOUT);
            retry_cnt <= retry_cnt_t'(`UART_SLAVE_RETRANSMITS);
            running   <= 1'b1;
        end else if (tmr.retry) begin
            // each retransmission gets a fresh wait
            wait_cnt  <= ack_wait_t'(`UART_SLAVE_ACK_TIMEOUT);
            retry_cnt <= retry_cnt - 1'b1;
        end else if (running && (wait_cnt != '0)) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    // stays high until a retry or clear
    assign tmr.timed_out    = running && (wait_cnt == '0);
    assign tmr.retries_left = (retry_cnt != '0);

endmodule

`default_nettype wire

//--- hw/slave_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module slave_fsm (
    input  logic                   clk,
    input  logic                   rstN,

    // master side
    input  logic                   valid,
    output logic                   ready,

    // link status and strobes
    input  logic                   g_rx_done,
    input  logic                   g_tx_ready,
    input  logic                   s_rx_done,
    input  logic                   s_tx_ready,
    input  logic [$bits(uart_slave_pkg::link_code_t)-1:0] s_byte_from_rx,
    output logic                   g_tx_start,
    output logic                   s_tx_start,

    // control frame decoder
    input  logic                   frame_hit,
    input  uart_slave_pkg::rw_op_t op,
    output logic                   sample_en,

    // write buffer
    output logic                   shift_en,
    output logic                   load_tx,
    input  logic                   word_full,

    // read buffer
    output logic                   rx_load,
    output logic                   status_load,
    output logic                   status_ack,
    output logic                   out_en,
    input  logic                   out_last,

    ack_timer_if.fsm               tmr
);
    import uart_slave_pkg::*;

    slave_state_t state;
    slave_state_t state_next;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next     = state;
        ready          = 1'b0;
        sample_en      = 1'b0;
        shift_en       = 1'b0;
        load_tx        = 1'b0;
        rx_load        = 1'b0;
        status_load    = 1'b0;
        status_ack     = 1'b0;
        out_en         = 1'b0;
        g_tx_start     = 1'b0;
        s_tx_start     = 1'b0;
        tmr.start      = 1'b0;
        tmr.retry      = 1'b0;
        tmr.tick_clear = 1'b0;

        case (state)
            IDLE: begin
                ready = 1'b1;
                // keep the decoder from treating the hit cycle as a new frame
                sample_en = !frame_hit;
                if (frame_hit) begin
                    state_next = FRAME;
                end
            end
            // one cycle with ready low before the data phase
            FRAME: begin
                state_next = (op == OP_WRITE) ? WRITE_IN : RX_WAIT;
            end
            WRITE_IN: begin
                ready    = !word_full;
                shift_en = valid && !word_full;
                if (word_full) begin
                    load_tx    = 1'b1;
                    state_next = TX_START;
                end
            end
            TX_START: begin
                if (s_tx_ready) begin
                    s_tx_start = 1'b1;
                    tmr.start  = 1'b1;
                    state_next = ACK_WAIT;
                end
            end
            ACK_WAIT: begin
                if (s_rx_done) begin
                    status_load    = 1'b1;
                    status_ack     = (s_byte_from_rx == LINK_ACK);
                    tmr.tick_clear = 1'b1;
                    state_next     = IDLE;
                end else if (tmr.timed_out && tmr.retries_left) begin
                    // resend the held word once the transmitter is free
                    if (s_tx_ready) begin
                        s_tx_start = 1'b1;
                        tmr.retry  = 1'b1;
                    end
                end else if (tmr.timed_out) begin
                    // no reply after the last attempt counts as NAK
                    status_load    = 1'b1;
                    tmr.tick_clear = 1'b1;
                    state_next     = IDLE;
                end
            end
            RX_WAIT: begin
                if (g_rx_done) begin
                    rx_load    = 1'b1;
                    state_next = SEND_ACK;
                end
            end
            SEND_ACK: begin
                if (g_tx_ready) begin
                    g_tx_start = 1'b1;
                    state_next = READ_OUT;
                end
            end
            READ_OUT: begin
                ready  = 1'b1;
                out_en = 1'b1;
                if (out_last) begin
                    state_next = READ_DONE;
                end
            end
            READ_DONE: begin
                if (valid) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/uart_slave_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_slave_params.svh"

module uart_slave_top (
    input  logic clk,
    input  logic rstN,

    // master side
    input  logic control,
    input  logic wD,
    input  logic valid,
    output logic rD,
    output logic ready,

    // get link
    input  logic                                          g_rx_done,
    input  logic [`UART_SLAVE_DATA_WIDTH-1:0]             g_byte_from_rx,
    input  logic                                          g_tx_ready,
    output logic                                          g_tx_start,
    output logic [$bits(uart_slave_pkg::link_code_t)-1:0] g_byte_for_tx,

    // send link
    input  logic                                          s_rx_done,
    input  logic [$bits(uart_slave_pkg::link_code_t)-1:0] s_byte_from_rx,
    input  logic                                          s_tx_ready,
    output logic                                          s_tx_start,
    output logic [`UART_SLAVE_DATA_WIDTH-1:0]             s_byte_for_tx
);
    import uart_slave_pkg::*;

    logic   frame_hit;
    rw_op_t op;
    logic   sample_en;
    logic   shift_en;
    logic   load_tx;
    logic   word_full;
    logic   rx_load;
    logic   status_load;
    logic   status_ack;
    logic   out_en;
    logic   out_last;

    ack_timer_if tmr_if ();

    // the get link only ever answers with ACK
    assign g_byte_for_tx = LINK_ACK;

    control_frame_decoder decoder_i (
        .clk       (clk),
        .rstN      (rstN),
        .control   (control),
        .sample_en (sample_en),
        .frame_hit (frame_hit),
        .op        (op)
    );

    write_shift_buffer wr_buf_i (
        .clk       (clk),
        .rstN      (rstN),
        .wD        (wD),
        .shift_en  (shift_en),
        .load_tx   (load_tx),
        .word_full (word_full),
        .tx_word   (s_byte_for_tx)
    );

    read_shift_buffer rd_buf_i (
        .clk         (clk),
        .rstN        (rstN),
        .rx_load     (rx_load),
        .rx_word     (g_byte_from_rx),
        .status_load (status_load),
        .status_ack  (status_ack),
        .out_en      (out_en),
        .rD          (rD),
        .out_last    (out_last)
    );

    ack_timer timer_i (
        .clk  (clk),
        .rstN (rstN),
        .tmr  (tmr_if.timer)
    );

    slave_fsm fsm_i (
        .clk            (clk),
        .rstN           (rstN),
        .valid          (valid),
        .ready          (ready),
        .g_rx_done      (g_rx_done),
        .g_tx_ready     (g_tx_ready),
        .s_rx_done      (s_rx_done),
        .s_tx_ready     (s_tx_ready),
        .s_byte_from_rx (s_byte_from_rx),
        .g_tx_start     (g_tx_start),
        .s_tx_start     (s_tx_start),
        .frame_hit      (frame_hit),
        .op             (op),
        .sample_en      (sample_en),
        .shift_en       (shift_en),
        .load_tx        (load_tx),
        .word_full      (word_full),
        .rx_load        (rx_load),
        .status_load    (status_load),
        .status_ack     (status_ack),
        .out_en         (out_en),
        .out_last       (out_last),
        .tmr            (tmr_if.fsm)
    );

endmodule

`default_nettype wire

//--- tests/tb_uart_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_slave_params.svh"

module tb_uart_slave;
    import uart_slave_pkg::*;

    localparam int DATA_WIDTH   = `UART_SLAVE_DATA_WIDTH;
    localparam int ID_WIDTH     = `UART_SLAVE_ID_WIDTH;
    localparam int STATUS_BITS  = `UART_SLAVE_STATUS_BITS;
    localparam int FRAME_BITS   = `UART_SLAVE_FRAME_BITS;
    localparam int ACK_TIMEOUT  = `UART_SLAVE_ACK_TIMEOUT;
    localparam int RETRANSMITS  = `UART_SLAVE_RETRANSMITS;
    localparam int BURST_BITS   = STATUS_BITS + DATA_WIDTH;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TRANS    = 40;

    localparam logic [ID_WIDTH-1:0] SLAVE_ID = `UART_SLAVE_ID;

    // worst write has every attempt time out under back-pressure and gaps in valid
    localparam int WRITE_WORST = (RETRANSMITS + 1) * (ACK_TIMEOUT + 16) + FRAME_BITS
                                 + 4 * DATA_WIDTH + 64;
    localparam int READ_WORST  = FRAME_BITS + 2 * BURST_BITS + 32;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TRANS * (WRITE_WORST + READ_WORST + 8);

    logic                  clk;
    logic                  rstN;
    logic                  control;
    logic                  wD;
    logic                  valid;
    logic                  rD;
    logic                  ready;
    logic                  g_rx_done;
    logic [DATA_WIDTH-1:0] g_byte_from_rx;
    logic                  g_tx_ready;
    logic                  g_tx_start;
    logic [7:0]            g_byte_for_tx;
    logic                  s_rx_done;
    logic [7:0]            s_byte_from_rx;
    logic                  s_tx_ready;
    logic                  s_tx_start;
    logic [DATA_WIDTH-1:0] s_byte_for_tx;

    logic [15:0] lfsr_state;
    logic [3:0]  model_status;
    int          errors;
    int          checks;

    uart_slave_top dut_i (
        .clk            (clk),
        .rstN           (rstN),
        .control        (control),
        .wD             (wD),
        .valid          (valid),
        .rD             (rD),
        .ready          (ready),
        .g_rx_done      (g_rx_done),
        .g_byte_from_rx (g_byte_from_rx),
        .g_tx_ready     (g_tx_ready),
        .g_tx_start     (g_tx_start),
        .g_byte_for_tx  (g_byte_for_tx),
        .s_rx_done      (s_rx_done),
        .s_byte_from_rx (s_byte_from_rx),
        .s_tx_ready     (s_tx_ready),
        .s_tx_start     (s_tx_start),
        .s_byte_for_tx  (s_byte_for_tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] rand_field(input int n);
        logic [DATA_WIDTH-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[DATA_WIDTH-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("ERR %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            control <= 1'b0;
            valid   <= 1'b0;
            @(negedge clk);
            check_value("idle ready", 1, ready);
            check_value("idle strobes", 0, {g_tx_start, s_tx_start});
        end
    endtask

    // six frame bits, msb first, then the cycle where a hit drops ready
    task automatic send_frame(input logic [2:0] pattern, input logic [ID_WIDTH-1:0] id,
                              input logic rw, input logic hit);
        logic [FRAME_BITS-1:0] bits;
        bits = {pattern, id, rw};
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            @(posedge clk);
            control <= bits[i];
            @(negedge clk);
            check_value("frame strobes", 0, {g_tx_start, s_tx_start});
        end
        @(posedge clk);
        control <= 1'b0;
        @(negedge clk);
        @(posedge clk);
        @(negedge clk);
        check_value("frame ready", !hit, ready);
    endtask

    task automatic miss_transaction;
        logic [2:0]          pattern;
        logic [ID_WIDTH-1:0] id;
        logic                rw;
        pattern = `UART_SLAVE_START_PATTERN;
        id      = rand_field(ID_WIDTH);
        rw      = rand_field(1);
        if (rand_field(1)) begin
            // leading 1 still opens a frame
            pattern = {1'b1, 2'(rand_field(2))};
            if (pattern == 3'b111) begin
                pattern = 3'b110;
            end
        end else if (id == SLAVE_ID) begin
            id = id + 1'b1;
        end
        send_frame(pattern, id, rw, 1'b0);
        idle_cycles(4);
    endtask

    // mode 0 ack, 1 nak, 2 silence on every attempt, 3 random per attempt
    task automatic write_transaction(input int mode);
        logic [DATA_WIDTH-1:0] word;
        logic [7:0]            reply_code;
        logic [3:0]            exp_status;
        logic [1:0]            kind;
        logic                  replied;
        logic                  done;
        int                    taken;
        int                    pulses;
        int                    exp_pulses;
        int                    reply_in;
        send_frame(`UART_SLAVE_START_PATTERN, SLAVE_ID, OP_WRITE, 1'b1);
        word  = '0;
        taken = 0;
        while (taken < DATA_WIDTH) begin
            @(posedge clk);
            valid <= (rand_field(2) != 0);
            wD    <= rand_field(1);
            @(negedge clk);
            if (valid && ready) begin
                word = {word[DATA_WIDTH-2:0], wD};
                taken++;
            end
        end
        pulses     = 0;
        exp_pulses = RETRANSMITS + 1;
        reply_code = LINK_NAK;
        exp_status = reply_code[7:4];
        replied    = 1'b0;
        reply_in   = -1;
        done       = 1'b0;
        while (!done) begin
            @(posedge clk);
            valid      <= 1'b0;
            s_tx_ready <= rand_field(1);
            s_rx_done  <= (reply_in == 0);
            if (reply_in == 0) begin
                s_byte_from_rx <= reply_code;
            end
            if (reply_in >= 0) begin
                reply_in--;
            end
            @(negedge clk);
            check_value("write get strobe", 0, g_tx_start);
            if (ready) begin
                done = 1'b1;
            end else if (s_tx_start) begin
                pulses++;
                check_value("write tx ready", 1, s_tx_ready);
                check_value("write word", word, s_byte_for_tx);
                kind = (mode == 3) ? 2'(rand_field(2)) : 2'(mode);
                if (!replied && (kind < 2)) begin
                    replied    = 1'b1;
                    exp_pulses = pulses;
                    reply_code = (kind == 0) ? LINK_ACK : LINK_NAK;
                    exp_status = reply_code[7:4];
                    reply_in   = rand_field(4);
                end
            end
        end
        check_value("write attempts", exp_pulses, pulses);
        model_status = exp_status;
    endtask

    task automatic read_transaction;
        logic [DATA_WIDTH-1:0] word;
        logic [BURST_BITS-1:0] burst;
        logic                  in_burst;
        logic                  last_pulse;
        logic                  done;
        int                    burst_len;
        int                    acks;
        int                    wait_rx;
        send_frame(`UART_SLAVE_START_PATTERN, SLAVE_ID, OP_READ, 1'b1);
        word       = rand_field(DATA_WIDTH);
        wait_rx    = rand_field(3);
        burst      = '0;
        burst_len  = 0;
        acks       = 0;
        in_burst   = 1'b0;
        last_pulse = 1'b0;
        done       = 1'b0;
        while (!done) begin
            @(posedge clk);
            g_tx_ready <= rand_field(1);
            g_rx_done  <= (wait_rx == 0);
            if (wait_rx == 0) begin
                g_byte_from_rx <= word;
            end
            wait_rx--;
            @(negedge clk);
            if (last_pulse) begin
                check_value("read burst start", 1, ready);
            end
            if (acks == 0) begin
                check_value("read wait ready", 0, ready);
            end
            if (g_tx_start) begin
                acks++;
                check_value("read ack byte", LINK_ACK, g_byte_for_tx);
            end
            last_pulse = g_tx_start;
            if (ready) begin
                burst    = {burst[BURST_BITS-2:0], rD};
                burst_len++;
                in_burst = 1'b1;
            end else if (in_burst) begin
                done = 1'b1;
            end
        end
        check_value("read ack pulses", 1, acks);
        check_value("read burst length", BURST_BITS, burst_len);
        check_value("read data", {model_status, word}, burst);
        // slave holds ready low until the master ends the read
        repeat (int'(rand_field(2))) begin
            @(posedge clk);
            @(negedge clk);
            check_value("read hold ready", 0, ready);
        end
        @(posedge clk);
        valid <= 1'b1;
        @(negedge clk);
        check_value("read end ready", 0, ready);
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        check_value("read return idle", 1, ready);
    endtask

    initial begin
        logic [1:0] kind;
        int         write_count;
        control        = 1'b0;
        wD             = 1'b0;
        valid          = 1'b0;
        g_rx_done      = 1'b0;
        g_byte_from_rx = '0;
        g_tx_ready     = 1'b0;
        s_rx_done      = 1'b0;
        s_byte_from_rx = '0;
        s_tx_ready     = 1'b0;
        rstN           = 1'b0;
        lfsr_state     = 16'd89;
        model_status   = 4'h0;
        errors         = 0;
        checks         = 0;
        write_count    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        check_value("reset ready", 1, ready);
        check_value("reset strobes", 0, {g_tx_start, s_tx_start});
        check_value("reset rD", 0, rD);
        // status still 0000 here
        read_transaction();
        for (int t = 1; t < NUM_TRANS; t++) begin
            idle_cycles(int'(rand_field(2)) + 1);
            kind = rand_field(2);
            case (kind)
                2'd0: miss_transaction();
                2'd1: read_transaction();
                default: begin
                    write_transaction(write_count % 4);
                    write_count++;
                    read_transaction();
                end
            endcase
        end
        idle_cycles(2);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_slave.f
+incdir+hw
hw/uart_slave_pkg.sv
hw/ack_timer_if.sv
hw/control_frame_decoder.sv
hw/write_shift_buffer.sv
hw/read_shift_buffer.sv
hw/ack_timer.sv
hw/slave_fsm.sv
hw/uart_slave_top.sv
tests/tb_uart_slave.sv
